//--- hw/mem_pkg.sv
package mem_pkg;

    // *********************************************************************
    // widths
    // *********************************************************************
    localparam int xlen       = 64;
    localparam int inst_w     = 32;
    localparam int op_w       = 24;
    localparam int reg_id_w   = 5;
    localparam int strb_w     = 8;

    // local data ram, 2 KiB of doublewords
    localparam int mem_words  = 256;
    localparam int mem_addr_w = 8;

    // *********************************************************************
    // operation codes, flat enumeration from decode
    // *********************************************************************
    // loads
    localparam logic [op_w-1:0] op_lb    = 24'd11;
    localparam logic [op_w-1:0] op_lh    = 24'd12;
    localparam logic [op_w-1:0] op_lw    = 24'd13;
    localparam logic [op_w-1:0] op_lbu   = 24'd14;
    localparam logic [op_w-1:0] op_lhu   = 24'd15;
    localparam logic [op_w-1:0] op_lwu   = 24'd41;
    localparam logic [op_w-1:0] op_ld    = 24'd42;

    // stores
    localparam logic [op_w-1:0] op_sb    = 24'd16;
    localparam logic [op_w-1:0] op_sh    = 24'd17;
    localparam logic [op_w-1:0] op_sw    = 24'd18;
    localparam logic [op_w-1:0] op_sd    = 24'd43;

    // jumps, write back pc + 4
    localparam logic [op_w-1:0] op_jal   = 24'd4;
    localparam logic [op_w-1:0] op_jalr  = 24'h300;

    // csr ops, write back the second operand
    localparam logic [op_w-1:0] op_csrrw = 24'd49;
    localparam logic [op_w-1:0] op_csrrs = 24'd50;

    // codes returning the alu result
    localparam int alu_op_count = 38;
    localparam logic [op_w-1:0] alu_ops [alu_op_count] = '{
        24'h4000,  24'h5000,  24'h6000,  24'h7000,  24'h8000,
        24'h9000,  24'h10000, 24'h12000, 24'h13000, 24'h14000,
        24'h15000, 24'h16000, 24'h17000, 24'h18000, 24'h19000,
        24'h1a000, 24'h1b000, 24'h1d000, 24'h21000, 24'h22000,
        24'h24000, 24'h25000, 24'h26000, 24'h27000, 24'h28000,
        24'h29000, 24'h100,   24'h200,   24'h400,   24'h800,
        24'hc00,   24'd19,    24'd20,    24'd21,    24'd22,
        24'd23,    24'd24,    24'd47
    };

    // *********************************************************************
    // decode helpers
    // *********************************************************************
    function automatic logic is_alu_op(input logic [op_w-1:0] op);
        logic hit;
        hit = 1'b0;
        // linear search, small table
        for (int i = 0; i < alu_op_count; i++) begin
            if (op == alu_ops[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic is_load_op(input logic [op_w-1:0] op);
        logic hit;
        case (op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: begin
                hit = 1'b1;
            end
            default: begin
                hit = 1'b0;
            end
        endcase
        return hit;
    endfunction

endpackage

//--- hw/mem_pipe_reg.sv
`timescale 1ns/1ns

module mem_pipe_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ready,
    input  logic                         valid_in,
    input  logic [mem_pkg::xlen-1:0]     pc_in,
    input  logic [mem_pkg::inst_w-1:0]   inst_in,
    input  logic [mem_pkg::op_w-1:0]     opcode_in,
    input  logic [mem_pkg::xlen-1:0]     alu_result_in,
    input  logic [mem_pkg::xlen-1:0]     src2_in,
    output logic                         valid,
    output logic [mem_pkg::xlen-1:0]     pc,
    output logic [mem_pkg::inst_w-1:0]   inst,
    output logic [mem_pkg::op_w-1:0]     opcode,
    output logic [mem_pkg::xlen-1:0]     alu_result,
    output logic [mem_pkg::xlen-1:0]     src2,
    output logic [mem_pkg::reg_id_w-1:0] rd
);

    logic                       valid_q;
    logic [mem_pkg::xlen-1:0]   pc_q;
    logic [mem_pkg::inst_w-1:0] inst_q;
    logic [mem_pkg::op_w-1:0]   opcode_q;
    logic [mem_pkg::xlen-1:0]   alu_result_q;
    logic [mem_pkg::xlen-1:0]   src2_q;

    // load everything on ready, bubble comes in as valid low
    // no ready means hold the entry
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q      <= 1'b0;
            pc_q         <= '0;
            inst_q       <= '0;
            opcode_q     <= '0;
            alu_result_q <= '0;
            src2_q       <= '0;
        end else if (ready) begin
            valid_q      <= valid_in;
            pc_q         <= pc_in;
            inst_q       <= inst_in;
            opcode_q     <= opcode_in;
            alu_result_q <= alu_result_in;
            src2_q       <= src2_in;
        end
    end

    // pc and inst go to write-back as held
    assign valid      = valid_q;
    assign pc         = pc_q;
    assign inst       = inst_q;

    // invalid entry looks like op 0, so no write and no memory access
    assign opcode     = valid_q ? opcode_q : '0;
    assign alu_result = valid_q ? alu_result_q : '0;
    assign src2       = valid_q ? src2_q : '0;
    // destination register field of the instruction
    assign rd         = valid_q ? inst_q[11:7] : '0;

endmodule

//--- hw/store_align.sv
`timescale 1ns/1ns

module store_align (
    input  logic [mem_pkg::op_w-1:0]   opcode,
    input  logic [mem_pkg::xlen-1:0]   addr,
    input  logic [mem_pkg::xlen-1:0]   src2,
    output logic [mem_pkg::xlen-1:0]   wdata,
    output logic [mem_pkg::strb_w-1:0] wstrb
);

    logic [2:0]                  off;
    logic [5:0]                  shamt;
    logic [mem_pkg::xlen-1:0]    byte_data;
    logic [mem_pkg::xlen-1:0]    half_data;
    logic [mem_pkg::xlen-1:0]    word_data;
    logic [mem_pkg::strb_w-1:0]  byte_strb;
    logic [mem_pkg::strb_w-1:0]  half_strb;
    logic [mem_pkg::strb_w-1:0]  word_strb;

    // byte offset inside the doubleword
    assign off   = addr[2:0];
    assign shamt = {off, 3'b000};

    // byte lane
    assign byte_data = {{(mem_pkg::xlen-8){1'b0}}, src2[7:0]} << shamt;
    assign byte_strb = {{(mem_pkg::strb_w-1){1'b0}}, 1'b1} << off;

    // halfword lanes, offset 7 would cross into the next doubleword
    // so it is dropped with an empty mask
    assign half_data = (off == 3'd7) ? '0 :
                       {{(mem_pkg::xlen-16){1'b0}}, src2[15:0]} << shamt;
    assign half_strb = (off == 3'd7) ? '0 :
                       {{(mem_pkg::strb_w-2){1'b0}}, 2'b11} << off;

    // word goes to upper or lower half by addr bit 2
    assign word_data = addr[2] ? {src2[31:0], 32'b0} : {32'b0, src2[31:0]};
    assign word_strb = addr[2] ?
                       {{(mem_pkg::strb_w/2){1'b1}}, {(mem_pkg::strb_w/2){1'b0}}} :
                       {{(mem_pkg::strb_w/2){1'b0}}, {(mem_pkg::strb_w/2){1'b1}}};

    always_comb begin
        case (opcode)
            mem_pkg::op_sb: begin
                wdata = byte_data;
                wstrb = byte_strb;
            end
            mem_pkg::op_sh: begin
                wdata = half_data;
                wstrb = half_strb;
            end
            mem_pkg::op_sw: begin
                wdata = word_data;
                wstrb = word_strb;
            end
            mem_pkg::op_sd: begin
                wdata = src2;
                wstrb = '1;
            end
            // not a store, nothing written
            default: begin
                wdata = '0;
                wstrb = '0;
            end
        endcase
    end

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ns

module data_ram (
    input  logic                           clk,
    input  logic [mem_pkg::mem_addr_w-1:0] addr,
    input  logic [mem_pkg::xlen-1:0]       wdata,
    input  logic [mem_pkg::strb_w-1:0]     wstrb,
    output logic [mem_pkg::xlen-1:0]       rdata
);

    // doubleword storage, contents undefined until written
    logic [mem_pkg::xlen-1:0] mem [mem_pkg::mem_words];

    // *********************************************************************
    // write port
    // *********************************************************************
    // one enable per byte lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < mem_pkg::strb_w; i++) begin
            if (wstrb[i]) begin
                mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    // *********************************************************************
    // read port
    // *********************************************************************
    // async read, a load right after a store sees the new bytes
    assign rdata = mem[addr];

endmodule

//--- hw/load_extend.sv
`timescale 1ns/1ns

module load_extend (
    input  logic [mem_pkg::op_w-1:0] opcode,
    input  logic [2:0]               offset,
    input  logic [mem_pkg::xlen-1:0] rdata,
    output logic [mem_pkg::xlen-1:0] load_value
);

    logic [5:0]               shamt;
    logic [mem_pkg::xlen-1:0] shifted;
    logic [7:0]               byte_sel;
    logic [15:0]              half_sel;
    logic [31:0]              word_sel;

    // move the addressed byte down to lane 0
    assign shamt    = {offset, 3'b000};
    assign shifted  = rdata >> shamt;
    assign byte_sel = shifted[7:0];
    // no halfword across the doubleword edge, same as the store side
    assign half_sel = (offset == 3'd7) ? 16'h0 : shifted[15:0];
    // upper or lower word by bit 2
    assign word_sel = offset[2] ? rdata[mem_pkg::xlen-1:32] : rdata[31:0];

    always_comb begin
        case (opcode)
            // signed kinds
            mem_pkg::op_lb: begin
                load_value = {{(mem_pkg::xlen-8){byte_sel[7]}}, byte_sel};
            end
            mem_pkg::op_lh: begin
                load_value = {{(mem_pkg::xlen-16){half_sel[15]}}, half_sel};
            end
            mem_pkg::op_lw: begin
                load_value = {{(mem_pkg::xlen-32){word_sel[31]}}, word_sel};
            end
            // unsigned kinds
            mem_pkg::op_lbu: begin
                load_value = {{(mem_pkg::xlen-8){1'b0}}, byte_sel};
            end
            mem_pkg::op_lhu: begin
                load_value = {{(mem_pkg::xlen-16){1'b0}}, half_sel};
            end
            mem_pkg::op_lwu: begin
                load_value = {{(mem_pkg::xlen-32){1'b0}}, word_sel};
            end
            mem_pkg::op_ld: begin
                load_value = rdata;
            end
            default: begin
                load_value = '0;
            end
        endcase
    end

endmodule

//--- hw/wb_select.sv
`timescale 1ns/1ns

module wb_select (
    input  logic [mem_pkg::op_w-1:0] opcode,
    input  logic [mem_pkg::xlen-1:0] alu_result,
    input  logic [mem_pkg::xlen-1:0] src2,
    input  logic [mem_pkg::xlen-1:0] pc,
    input  logic [mem_pkg::xlen-1:0] load_value,
    output logic                     wen,
    output logic [mem_pkg::xlen-1:0] value
);

    logic                     is_alu;
    logic                     is_load;
    logic                     is_link;
    logic                     is_csr;
    logic [mem_pkg::xlen-1:0] link_value;

    // op classes
    assign is_alu  = mem_pkg::is_alu_op(opcode);
    assign is_load = mem_pkg::is_load_op(opcode);
    assign is_link = (opcode == mem_pkg::op_jal) || (opcode == mem_pkg::op_jalr);
    assign is_csr  = (opcode == mem_pkg::op_csrrw) || (opcode == mem_pkg::op_csrrs);

    // return address for jal and jalr
    assign link_value = pc + {{(mem_pkg::xlen-3){1'b0}}, 3'b100};

    // stores, bubbles and unknown codes write nothing
    assign wen = is_alu | is_load | is_link | is_csr;

    // classes are disjoint, order does not matter
    always_comb begin
        if (is_alu) begin
            value = alu_result;
        end else if (is_load) begin
            value = load_value;
        end else if (is_link) begin
            value = link_value;
        end else if (is_csr) begin
            // csr old value comes in on the second operand
            value = src2;
        end else begin
            value = '0;
        end
    end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  logic                         clk,
    input  logic                         rst,
    // from execute
    input  logic                         valid_ex_mem,
    output logic                         ready_ex_mem,
    input  logic [mem_pkg::xlen-1:0]     pc_ex_mem,
    input  logic [mem_pkg::inst_w-1:0]   inst_ex_mem,
    input  logic [mem_pkg::op_w-1:0]     opcode_in,
    input  logic [mem_pkg::xlen-1:0]     alu_result_in,
    input  logic [mem_pkg::xlen-1:0]     src2_in,
    // to write-back
    output logic                         valid_mem_wb,
    input  logic                         ready_mem_wb,
    output logic [mem_pkg::xlen-1:0]     pc_mem_wb,
    output logic [mem_pkg::inst_w-1:0]   inst_mem_wb,
    // register file write
    output logic                         reg_wr_wen,
    output logic [mem_pkg::reg_id_w-1:0] reg_wr_id,
    output logic [mem_pkg::xlen-1:0]     reg_wr_value
);

    logic [mem_pkg::op_w-1:0]   opcode;
    logic [mem_pkg::xlen-1:0]   alu_result;
    logic [mem_pkg::xlen-1:0]   src2;
    logic [mem_pkg::xlen-1:0]   pc;
    logic [mem_pkg::xlen-1:0]   wdata;
    logic [mem_pkg::strb_w-1:0] wstrb;
    logic [mem_pkg::xlen-1:0]   rdata;
    logic [mem_pkg::xlen-1:0]   load_value;

    // never blocks on its own, stalls only with write-back
    assign ready_ex_mem = ready_mem_wb;

    // *********************************************************************
    // stage register
    // *********************************************************************
    mem_pipe_reg u_pipe_reg (
        .clk           (clk),
        .rst           (rst),
        .ready         (ready_mem_wb),
        .valid_in      (valid_ex_mem),
        .pc_in         (pc_ex_mem),
        .inst_in       (inst_ex_mem),
        .opcode_in     (opcode_in),
        .alu_result_in (alu_result_in),
        .src2_in       (src2_in),
        .valid         (valid_mem_wb),
        .pc            (pc),
        .inst          (inst_mem_wb),
        .opcode        (opcode),
        .alu_result    (alu_result),
        .src2          (src2),
        .rd            (reg_wr_id)
    );

    assign pc_mem_wb = pc;

    // *********************************************************************
    // memory access
    // *********************************************************************
    store_align u_store_align (
        .opcode (opcode),
        .addr   (alu_result),
        .src2   (src2),
        .wdata  (wdata),
        .wstrb  (wstrb)
    );

    // doubleword index, upper address bits wrap
    data_ram u_data_ram (
        .clk   (clk),
        .addr  (alu_result[mem_pkg::mem_addr_w+2:3]),
        .wdata (wdata),
        .wstrb (wstrb),
        .rdata (rdata)
    );

    load_extend u_load_extend (
        .opcode     (opcode),
        .offset     (alu_result[2:0]),
        .rdata      (rdata),
        .load_value (load_value)
    );

    // *********************************************************************
    // write-back value
    // *********************************************************************
    wb_select u_wb_select (
        .opcode     (opcode),
        .alu_result (alu_result),
        .src2       (src2),
        .pc         (pc),
        .load_value (load_value),
        .wen        (reg_wr_wen),
        .value      (reg_wr_value)
    );

endmodule

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage;

    localparam int txn_count  = 3000;
    localparam int cycle_limit = 16 + txn_count * 4;

    logic                         clk;
    logic                         rst;
    logic                         valid_ex_mem;
    logic                         ready_ex_mem;
    logic [mem_pkg::xlen-1:0]     pc_ex_mem;
    logic [mem_pkg::inst_w-1:0]   inst_ex_mem;
    logic [mem_pkg::op_w-1:0]     opcode_in;
    logic [mem_pkg::xlen-1:0]     alu_result_in;
    logic [mem_pkg::xlen-1:0]     src2_in;
    logic                         valid_mem_wb;
    logic                         ready_mem_wb;
    logic [mem_pkg::xlen-1:0]     pc_mem_wb;
    logic [mem_pkg::inst_w-1:0]   inst_mem_wb;
    logic                         reg_wr_wen;
    logic [mem_pkg::reg_id_w-1:0] reg_wr_id;
    logic [mem_pkg::xlen-1:0]     reg_wr_value;

    // reference model of the stage register and the byte memory
    logic                         m_valid;
    logic [mem_pkg::xlen-1:0]     m_pc;
    logic [mem_pkg::inst_w-1:0]   m_inst;
    logic [mem_pkg::op_w-1:0]     m_op;
    logic [mem_pkg::xlen-1:0]     m_alu;
    logic [mem_pkg::xlen-1:0]     m_src2;
    logic [7:0]                   m_mem [mem_pkg::mem_words][8];

    logic [mem_pkg::op_w-1:0] load_ops [7] = '{mem_pkg::op_lb, mem_pkg::op_lh, mem_pkg::op_lw,
        mem_pkg::op_lbu, mem_pkg::op_lhu, mem_pkg::op_lwu, mem_pkg::op_ld};
    logic [mem_pkg::op_w-1:0] store_ops [4] = '{mem_pkg::op_sb, mem_pkg::op_sh,
        mem_pkg::op_sw, mem_pkg::op_sd};

    int errors;
    int checks;
    int cycle_count;
    int stall_count;

    mem_stage uut (
        .clk           (clk),
        .rst           (rst),
        .valid_ex_mem  (valid_ex_mem),
        .ready_ex_mem  (ready_ex_mem),
        .pc_ex_mem     (pc_ex_mem),
        .inst_ex_mem   (inst_ex_mem),
        .opcode_in     (opcode_in),
        .alu_result_in (alu_result_in),
        .src2_in       (src2_in),
        .valid_mem_wb  (valid_mem_wb),
        .ready_mem_wb  (ready_mem_wb),
        .pc_mem_wb     (pc_mem_wb),
        .inst_mem_wb   (inst_mem_wb),
        .reg_wr_wen    (reg_wr_wen),
        .reg_wr_id     (reg_wr_id),
        .reg_wr_value  (reg_wr_value)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // *********************************************************************
    // model helpers
    // *********************************************************************
    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // write-back class of a code (0 none 1 alu 2 load 3 link 4 csr)
    function automatic int op_class(input logic [mem_pkg::op_w-1:0] op);
        int cls;
        cls = 0;
        for (int i = 0; i < mem_pkg::alu_op_count; i++) begin
            if (op == mem_pkg::alu_ops[i]) begin
                cls = 1;
            end
        end
        for (int i = 0; i < 7; i++) begin
            if (op == load_ops[i]) begin
                cls = 2;
            end
        end
        if (op == mem_pkg::op_jal || op == mem_pkg::op_jalr) begin
            cls = 3;
        end
        if (op == mem_pkg::op_csrrw || op == mem_pkg::op_csrrs) begin
            cls = 4;
        end
        return cls;
    endfunction

    // byte placement into the model memory
    task automatic model_store(input logic [23:0] op, input logic [63:0] addr,
                               input logic [63:0] data);
        int idx;
        int off;
        int base;
        idx  = addr[10:3];
        off  = addr[2:0];
        base = addr[2] ? 4 : 0;
        if (op == mem_pkg::op_sb) begin
            m_mem[idx][off] = data[7:0];
        end else if (op == mem_pkg::op_sh && off != 7) begin
            m_mem[idx][off]     = data[7:0];
            m_mem[idx][off + 1] = data[15:8];
        end else if (op == mem_pkg::op_sw) begin
            for (int k = 0; k < 4; k++) begin
                m_mem[idx][base + k] = data[8*k +: 8];
            end
        end else if (op == mem_pkg::op_sd) begin
            for (int k = 0; k < 8; k++) begin
                m_mem[idx][k] = data[8*k +: 8];
            end
        end
    endtask

    function automatic logic [63:0] model_load(input logic [23:0] op, input logic [63:0] addr);
        int         idx;
        int         off;
        int         base;
        logic [7:0] b;
        logic [15:0] h;
        logic [31:0] w;
        logic [63:0] d;
        idx  = addr[10:3];
        off  = addr[2:0];
        base = addr[2] ? 4 : 0;
        b    = m_mem[idx][off];
        // halfword at offset 7 reads as zero
        h    = (off == 7) ? 16'h0 : {m_mem[idx][(off + 1) % 8], m_mem[idx][off]};
        w    = {m_mem[idx][base + 3], m_mem[idx][base + 2],
                m_mem[idx][base + 1], m_mem[idx][base]};
        for (int k = 0; k < 8; k++) begin
            d[8*k +: 8] = m_mem[idx][k];
        end
        case (op)
            mem_pkg::op_lb:  return {{56{b[7]}}, b};
            mem_pkg::op_lh:  return {{48{h[15]}}, h};
            mem_pkg::op_lw:  return {{32{w[31]}}, w};
            mem_pkg::op_lbu: return {56'h0, b};
            mem_pkg::op_lhu: return {48'h0, h};
            mem_pkg::op_lwu: return {32'h0, w};
            mem_pkg::op_ld:  return d;
            default:         return 64'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // compare outputs with the model entry at the falling edge
    task automatic check_outputs();
        logic [23:0] g_op;
        logic [63:0] g_alu;
        logic [63:0] g_src2;
        logic [63:0] exp_val;
        int          cls;
        g_op    = m_valid ? m_op : '0;
        g_alu   = m_valid ? m_alu : '0;
        g_src2  = m_valid ? m_src2 : '0;
        cls     = op_class(g_op);
        exp_val = (cls == 1) ? g_alu :
                  (cls == 2) ? model_load(g_op, g_alu) :
                  (cls == 3) ? m_pc + 64'd4 :
                  (cls == 4) ? g_src2 : 64'h0;
        check_value("ready_ex_mem", ready_ex_mem, ready_mem_wb);
        check_value("valid_mem_wb", valid_mem_wb, m_valid);
        check_value("pc_mem_wb", pc_mem_wb, m_pc);
        check_value("inst_mem_wb", inst_mem_wb, m_inst);
        check_value("reg_wr_wen", reg_wr_wen, cls != 0);
        check_value("reg_wr_id", reg_wr_id, m_valid ? m_inst[11:7] : 5'd0);
        check_value("reg_wr_value", reg_wr_value, exp_val);
    endtask

    // drive at the falling edge and step the model, then check one cycle later
    task automatic cycle(input logic rdy, input logic vld, input logic [23:0] op,
                         input logic [63:0] alu, input logic [63:0] src2);
        ready_mem_wb  = rdy;
        valid_ex_mem  = vld;
        opcode_in     = op;
        alu_result_in = alu;
        src2_in       = src2;
        pc_ex_mem     = {$urandom, $urandom} & ~64'h3;
        inst_ex_mem   = $urandom;
        // a held store writes on every edge even while stalled
        if (m_valid) begin
            model_store(m_op, m_alu, m_src2);
        end
        if (rdy) begin
            m_valid = vld;
            m_pc    = pc_ex_mem;
            m_inst  = inst_ex_mem;
            m_op    = op;
            m_alu   = alu;
            m_src2  = src2;
        end
        @(negedge clk);
        check_outputs();
    endtask

    // maybe a stall cycle with junk inputs before the accepting cycle
    task automatic do_txn(input logic vld, input logic [23:0] op, input logic [63:0] alu,
                          input logic [63:0] src2);
        if ($urandom_range(0, 99) < 30) begin
            stall_count++;
            cycle(1'b0, $urandom_range(0, 1), $urandom, rand64(), rand64());
        end
        cycle(1'b1, vld, op, alu, src2);
    endtask

    function automatic logic [23:0] pick_op(input int cls);
        case (cls)
            0: return mem_pkg::alu_ops[$urandom_range(0, mem_pkg::alu_op_count - 1)];
            1: return $urandom_range(0, 1) ? mem_pkg::op_jal : mem_pkg::op_jalr;
            2: return $urandom_range(0, 1) ? mem_pkg::op_csrrw : mem_pkg::op_csrrs;
            3: return load_ops[$urandom_range(0, 6)];
            4: return store_ops[$urandom_range(0, 3)];
            // codes outside every class including the bubble code
            default: return $urandom_range(0, 3) == 0 ? 24'h0 : {8'hf0, 16'($urandom)};
        endcase
    endfunction

    // *********************************************************************
    // stimulus
    // *********************************************************************
    initial begin
        int          seed_dummy;
        int          cls;
        int          done;
        logic [63:0] addr;
        seed_dummy    = $urandom(3);
        errors        = 0;
        checks        = 0;
        stall_count   = 0;
        done          = 0;
        rst           = 1'b1;
        valid_ex_mem  = 1'b0;
        ready_mem_wb  = 1'b1;
        pc_ex_mem     = '0;
        inst_ex_mem   = '0;
        opcode_in     = '0;
        alu_result_in = '0;
        src2_in       = '0;
        m_valid       = 1'b0;
        m_pc          = '0;
        m_inst        = '0;
        m_op          = '0;
        m_alu         = '0;
        m_src2        = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // outputs idle and zero out of reset
        check_outputs();
        // fill the whole ram with doubleword stores
        for (int i = 0; i < mem_pkg::mem_words; i++) begin
            do_txn(1'b1, mem_pkg::op_sd, 64'(i * 8), rand64());
            done++;
        end
        // every store size at every offset followed by every load kind there
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off++) begin
                addr = 64'($urandom_range(0, 255) * 8 + off);
                do_txn(1'b1, store_ops[s], addr, rand64());
                done++;
                for (int l = 0; l < 7; l++) begin
                    do_txn(1'b1, load_ops[l], addr, rand64());
                    done++;
                end
            end
        end
        // random mix of all classes and bubbles
        while (done < txn_count) begin
            cls  = $urandom_range(0, 5);
            addr = (cls == 3 || cls == 4) ? 64'($urandom_range(0, 2047)) : rand64();
            do_txn($urandom_range(0, 9) != 0, pick_op(cls), addr, rand64());
            done++;
        end
        // flush the last entry
        cycle(1'b1, 1'b0, '0, '0, '0);
        $display("errors %0d in %0d checks, %0d stall cycles", errors, checks, stall_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // run limit in clock cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, stimulus did not finish", cycle_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- verilog.f
hw/mem_pkg.sv
hw/mem_pipe_reg.sv
hw/store_align.sv
hw/data_ram.sv
hw/load_extend.sv
hw/wb_select.sv
hw/mem_stage.sv
tb/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - hw/mem_pkg.sv
  - hw/mem_pipe_reg.sv
  - hw/store_align.sv
  - hw/data_ram.sv
  - hw/load_extend.sv
  - hw/wb_select.sv
  - hw/mem_stage.sv
  - target: simulation
    files:
      - tb/tb_mem_stage.sv
